// ==== logic/rdm_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// Widths and burst limits shared by the RDM read DMA RTL and its testbench
// Burst size must stay within 4 KB and RDM_FIFO_DEPTH must match the limit
////////////////////////////////////////////////////////////////////////////
`ifndef RDM_DEFS_SVH
`define RDM_DEFS_SVH

// AXI address and register address width
`define RDM_ADDR_W          32

// Data path, one beat is 4 bytes
`define RDM_DATA_W          32
`define RDM_BEAT_BYTES_LOG  2

// Full burst, min of 256 beats and 4096 bytes per beat size
`define RDM_BURST_BEATS     256
`define RDM_BURST_LOG       8
// Also the start address alignment
`define RDM_BURST_BYTES     1024

// Size register width in bytes
`define RDM_XFER_W          20

// Bursts in flight, AR handshake to last beat drained
`define RDM_MAX_OUTSTANDING 2
// Holds every beat of all outstanding bursts
`define RDM_FIFO_DEPTH      (`RDM_BURST_BEATS * `RDM_MAX_OUTSTANDING)

// APB register space
`define RDM_APB_ADDR_W      8

`endif

// ==== logic/rdm_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types of the RDM read DMA, register map is one 32-bit word per entry
////////////////////////////////////////////////////////////////////////////
`include "rdm_defs.svh"

package rdm_pkg;

  //////////////////////////////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////////////////////////////
  typedef enum logic [`RDM_APB_ADDR_W-1:0] {
    // Bit 0 start on write, busy on read
    REG_CTRL   = 8'h00,
    // Bit 0 sticky done, write 1 to clear
    REG_STATUS = 8'h04,
    // Start byte address, aligned down by the engine
    REG_ADDR   = 8'h08,
    // Transfer size in bytes
    REG_SIZE   = 8'h0C
  } reg_addr_e;

  //////////////////////////////////////////////////////////////////////////
  // AR channel issuer
  //////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    AR_IDLE,
    AR_ISSUE,
    AR_STALL
  } ar_state_e;

endpackage : rdm_pkg

// ==== logic/rdm_ctrl_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Transfer request from the registers, start only while busy is low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

interface rdm_ctrl_if;

  // One-cycle launch pulse
  logic                   start;
  // Sampled with start
  logic [`RDM_ADDR_W-1:0] addr_offset;
  logic [`RDM_XFER_W-1:0] xfer_bytes;
  // Engine status back to the registers
  logic                   busy;
  // One-cycle pulse after the final rlast
  logic                   done;

  modport regs (
    output start,
    output addr_offset,
    output xfer_bytes,
    input  busy,
    input  done
  );

  modport engine (
    input  start,
    input  addr_offset,
    input  xfer_bytes,
    output busy,
    output done
  );

endinterface : rdm_ctrl_if

// ==== logic/rdm_apb_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// APB slave, no wait states, pslverr on any unmapped address
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_apb_regs
  import rdm_pkg::*;
(
  input  logic                       aclk,
  input  logic                       areset,
  // APB slave
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`RDM_APB_ADDR_W-1:0] paddr,
  input  logic [`RDM_DATA_W-1:0]     pwdata,
  output logic [`RDM_DATA_W-1:0]     prdata,
  output logic                       pready,
  output logic                       pslverr,
  // Request towards the engine
  rdm_ctrl_if.regs                   ctrl
);

  logic                   access;
  logic                   addr_hit;
  logic                   wr_ctrl;
  logic                   wr_status;
  logic                   wr_addr;
  logic                   wr_size;
  logic [`RDM_ADDR_W-1:0] addr_r;
  logic [`RDM_XFER_W-1:0] size_r;
  logic                   done_flag;
  logic                   start_r;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  // Access phase of an APB transfer
  assign access = psel & penable;

  always_comb begin
    case (paddr)
      REG_CTRL, REG_STATUS, REG_ADDR, REG_SIZE: addr_hit = 1'b1;
      default:                                  addr_hit = 1'b0;
    endcase
  end

  assign wr_ctrl   = access & pwrite & (paddr == REG_CTRL);
  assign wr_status = access & pwrite & (paddr == REG_STATUS);
  assign wr_addr   = access & pwrite & (paddr == REG_ADDR);
  assign wr_size   = access & pwrite & (paddr == REG_SIZE);

  // Never stalls
  assign pready  = 1'b1;
  assign pslverr = access & ~addr_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      addr_r    <= '0;
      size_r    <= '0;
      done_flag <= 1'b0;
      start_r   <= 1'b0;
    end else begin
      if (wr_addr) begin
        addr_r <= pwdata[`RDM_ADDR_W-1:0];
      end
      if (wr_size) begin
        size_r <= pwdata[`RDM_XFER_W-1:0];
      end
      // Launch only from idle with something to move
      // start_r covers the cycle before busy rises
      start_r <= wr_ctrl & pwdata[0] & (size_r != '0) & ~ctrl.busy & ~start_r;
      // Set wins over a clear in the same cycle
      if (ctrl.done) begin
        done_flag <= 1'b1;
      end else if (wr_status && pwdata[0]) begin
        done_flag <= 1'b0;
      end
    end
  end

  // Request fields stay stable for the whole transfer
  assign ctrl.start       = start_r;
  assign ctrl.addr_offset = addr_r;
  assign ctrl.xfer_bytes  = size_r;

  // Read data in the access phase
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_CTRL:   prdata[0] = ctrl.busy;
      REG_STATUS: prdata[0] = done_flag;
      REG_ADDR:   prdata    = addr_r;
      REG_SIZE:   prdata[`RDM_XFER_W-1:0] = size_r;
      default:    prdata    = '0;
    endcase
  end

endmodule : rdm_apb_regs

// ==== logic/rdm_burst_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// AR issuer, assumes nonzero size and no start while busy
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_burst_engine
  import rdm_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,
  rdm_ctrl_if.engine             ctrl,
  input  logic                   burst_received,
  input  logic                   burst_drained,
  // AXI read address channel
  output logic                   arvalid,
  input  logic                   arready,
  output logic [`RDM_ADDR_W-1:0] araddr,
  output logic [7:0]             arlen,
  output logic                   done
);

  localparam int TOTAL_W = `RDM_XFER_W - `RDM_BEAT_BYTES_LOG;
  localparam int CNT_W   = TOTAL_W - `RDM_BURST_LOG;
  localparam int VAC_W   = $clog2(`RDM_MAX_OUTSTANDING + 1);
  localparam logic [`RDM_ADDR_W-1:0] ADDR_MASK = `RDM_BURST_BYTES - 1;

  ar_state_e              state;
  logic                   busy_r;
  logic                   load_q;
  logic                   done_r;
  logic [TOTAL_W-1:0]     beats_m1;
  logic [`RDM_ADDR_W-1:0] base_addr;
  logic [`RDM_ADDR_W-1:0] addr_r;
  logic [CNT_W-1:0]       ar_to_go;
  logic [CNT_W-1:0]       r_to_go;
  logic                   ar_final;
  logic                   r_final;
  logic                   arxfer;
  logic [VAC_W-1:0]       vacancy;
  logic [VAC_W-1:0]       vac_next;

  ////////////////////////////////////////////////////////////////////////////
  // Request pre-processing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl.start) begin
      // Beats minus one, a partial beat counts as whole
      if (ctrl.xfer_bytes[`RDM_BEAT_BYTES_LOG-1:0] != '0) begin
        beats_m1 <= ctrl.xfer_bytes[`RDM_XFER_W-1:`RDM_BEAT_BYTES_LOG];
      end else begin
        beats_m1 <= ctrl.xfer_bytes[`RDM_XFER_W-1:`RDM_BEAT_BYTES_LOG] - 1'b1;
      end
      base_addr <= ctrl.addr_offset & ~ADDR_MASK;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy_r <= 1'b0;
      load_q <= 1'b0;
      done_r <= 1'b0;
    end else begin
      // Counters load one cycle after capture
      load_q <= ctrl.start;
      done_r <= burst_received & r_final & busy_r;
      if (ctrl.start) begin
        busy_r <= 1'b1;
      end else if (done_r) begin
        busy_r <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Burst counters
  ////////////////////////////////////////////////////////////////////////////
  // Upper bits count full bursts ahead of the final one
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_to_go <= '0;
      r_to_go  <= '0;
    end else begin
      if (load_q) begin
        ar_to_go <= beats_m1[TOTAL_W-1:`RDM_BURST_LOG];
      end else if (arxfer && !ar_final) begin
        ar_to_go <= ar_to_go - 1'b1;
      end
      if (load_q) begin
        r_to_go <= beats_m1[TOTAL_W-1:`RDM_BURST_LOG];
      end else if (burst_received && !r_final) begin
        r_to_go <= r_to_go - 1'b1;
      end
    end
  end

  assign ar_final = (ar_to_go == '0);
  assign r_final  = (r_to_go == '0);

  // Free slots, taken at AR handshake and returned when drained
  always_comb begin
    vac_next = vacancy;
    if (arxfer && !burst_drained) begin
      vac_next = vacancy - 1'b1;
    end else if (!arxfer && burst_drained) begin
      vac_next = vacancy + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= VAC_W'(`RDM_MAX_OUTSTANDING);
    end else begin
      vacancy <= vac_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AR issue FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= AR_IDLE;
    end else begin
      case (state)
        AR_IDLE: begin
          if (load_q) begin
            state <= (vac_next != '0) ? AR_ISSUE : AR_STALL;
          end
        end
        AR_ISSUE: begin
          if (arxfer) begin
            if (ar_final) begin
              state <= AR_IDLE;
            end else if (vac_next == '0) begin
              state <= AR_STALL;
            end
          end
        end
        AR_STALL: begin
          if (vac_next != '0) begin
            state <= AR_ISSUE;
          end
        end
        default: state <= AR_IDLE;
      endcase
    end
  end

  // Next burst address after each handshake
  always_ff @(posedge aclk) begin
    if (load_q) begin
      addr_r <= base_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + `RDM_BURST_BYTES;
    end
  end

  assign arvalid = (state == AR_ISSUE);
  assign arxfer  = arvalid & arready;
  assign araddr  = addr_r;
  // Remainder length only on the last burst
  assign arlen   = ar_final ? 8'(beats_m1[`RDM_BURST_LOG-1:0]) : 8'(`RDM_BURST_BEATS - 1);

  assign done      = done_r;
  assign ctrl.done = done_r;
  assign ctrl.busy = busy_r;

endmodule : rdm_burst_engine

// ==== logic/rdm_read_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// FWFT beat FIFO, never fills because the engine limits bursts in flight
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_read_fifo (
  input  logic                   aclk,
  input  logic                   areset,
  // AXI read data channel
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [`RDM_DATA_W-1:0] rdata,
  input  logic                   rlast,
  // Stream master
  output logic                   tvalid,
  input  logic                   tready,
  output logic [`RDM_DATA_W-1:0] tdata,
  output logic                   tlast,
  // Burst events to the engine
  output logic                   burst_received,
  output logic                   burst_drained
);

  localparam int DEPTH = `RDM_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // Last flag kept in the top bit
  logic [`RDM_DATA_W:0] mem [DEPTH];
  // Extra wrap bit tells full from empty
  logic [AW:0]          wr_ptr;
  logic [AW:0]          rd_ptr;
  logic                 wr_en;
  logic                 rd_en;
  logic                 empty;

  // Space is guaranteed upstream
  assign rready = 1'b1;
  assign wr_en  = rvalid & rready;

  assign empty  = (wr_ptr == rd_ptr);
  assign tvalid = ~empty;
  assign rd_en  = tvalid & tready;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= {rlast, rdata};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry, holds while tready is low
  assign tdata = mem[rd_ptr[AW-1:0]][`RDM_DATA_W-1:0];
  assign tlast = mem[rd_ptr[AW-1:0]][`RDM_DATA_W];

  // One pulse per burst at each side
  assign burst_received = wr_en & rlast;
  assign burst_drained  = rd_en & tlast;

endmodule : rdm_read_fifo

// ==== logic/rdm_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Read DMA top, APB control in, AXI read out, data as AXI4-Stream
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_top (
  input  logic                       aclk,
  input  logic                       areset,
  // APB slave
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`RDM_APB_ADDR_W-1:0] paddr,
  input  logic [`RDM_DATA_W-1:0]     pwdata,
  output logic [`RDM_DATA_W-1:0]     prdata,
  output logic                       pready,
  output logic                       pslverr,
  // AXI read master
  output logic                       arvalid,
  input  logic                       arready,
  output logic [`RDM_ADDR_W-1:0]     araddr,
  output logic [7:0]                 arlen,
  input  logic                       rvalid,
  output logic                       rready,
  input  logic [`RDM_DATA_W-1:0]     rdata,
  input  logic                       rlast,
  // Stream master
  output logic                       tvalid,
  input  logic                       tready,
  output logic [`RDM_DATA_W-1:0]     tdata,
  output logic                       tlast,
  // Transfer complete
  output logic                       done
);

  logic burst_received;
  logic burst_drained;

  // Registers to engine request path
  rdm_ctrl_if ctrl_if ();

  rdm_apb_regs regs_i (
    .aclk    (aclk),
    .areset  (areset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ctrl    (ctrl_if.regs)
  );

  rdm_burst_engine engine_i (
    .aclk           (aclk),
    .areset         (areset),
    .ctrl           (ctrl_if.engine),
    .burst_received (burst_received),
    .burst_drained  (burst_drained),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .arlen          (arlen),
    .done           (done)
  );

  // rready comes out of the FIFO tied high
  rdm_read_fifo fifo_i (
    .aclk           (aclk),
    .areset         (areset),
    .rvalid         (rvalid),
    .rready         (rready),
    .rdata          (rdata),
    .rlast          (rlast),
    .tvalid         (tvalid),
    .tready         (tready),
    .tdata          (tdata),
    .tlast          (tlast),
    .burst_received (burst_received),
    .burst_drained  (burst_drained)
  );

endmodule : rdm_top

// ==== dv/rdm_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// Protocol and data checker bound into rdm_top, expects memory data = address
// Assumes each stream is drained before the next transfer is started
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_chk
  import rdm_pkg::*;
(
  input logic                       aclk,
  input logic                       areset,
  input logic                       psel,
  input logic                       penable,
  input logic                       pwrite,
  input logic [`RDM_APB_ADDR_W-1:0] paddr,
  input logic [`RDM_DATA_W-1:0]     pwdata,
  input logic                       pready,
  input logic                       pslverr,
  input logic                       arvalid,
  input logic                       arready,
  input logic [`RDM_ADDR_W-1:0]     araddr,
  input logic [7:0]                 arlen,
  input logic                       rvalid,
  input logic                       rready,
  input logic                       rlast,
  input logic                       tvalid,
  input logic                       tready,
  input logic [`RDM_DATA_W-1:0]     tdata,
  input logic                       tlast,
  input logic                       done
);

  int unsigned            fail_cnt = 0;
  logic                   wr;
  logic                   launch;
  logic                   map_hit;
  logic                   active;
  logic                   done_exp;
  logic [`RDM_ADDR_W-1:0] addr_sh;
  logic [`RDM_ADDR_W-1:0] base;
  logic [`RDM_ADDR_W-1:0] exp_araddr;
  logic [7:0]             exp_arlen;
  logic [`RDM_DATA_W-1:0] exp_tdata;
  logic                   exp_tlast;
  int unsigned            size_sh;
  int unsigned            launch_beats;
  int unsigned            total_beats;
  int unsigned            ar_left;
  int unsigned            rb_left;
  int unsigned            out_cnt;
  int unsigned            s_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Shadow of the register block and the expected transfer
  ////////////////////////////////////////////////////////////////////////////
  assign wr     = psel & penable & pwrite;
  // Same launch rule as the registers, idle and nonzero size
  assign launch = wr & (paddr == REG_CTRL) & pwdata[0] & (size_sh != 0) & ~active;
  // Mapped words of the register block
  assign map_hit = paddr inside {REG_CTRL, REG_STATUS, REG_ADDR, REG_SIZE};
  // Partial beat rounds up
  assign launch_beats = (size_sh + (1 << `RDM_BEAT_BYTES_LOG) - 1) >> `RDM_BEAT_BYTES_LOG;

  // Full bursts first, remainder on the last one
  assign exp_arlen = (ar_left > 1) ? 8'(`RDM_BURST_BEATS - 1) :
                                     8'((total_beats - 1) % `RDM_BURST_BEATS);
  assign exp_tdata = base + (s_idx << `RDM_BEAT_BYTES_LOG);
  assign exp_tlast = ((s_idx % `RDM_BURST_BEATS) == `RDM_BURST_BEATS - 1) ||
                     (s_idx == total_beats - 1);

  always_ff @(posedge aclk) begin
    if (areset) begin
      active      <= 1'b0;
      done_exp    <= 1'b0;
      addr_sh     <= '0;
      size_sh     <= 0;
      base        <= '0;
      exp_araddr  <= '0;
      total_beats <= 0;
      ar_left     <= 0;
      rb_left     <= 0;
      out_cnt     <= 0;
      s_idx       <= 0;
    end else begin
      if (wr && paddr == REG_ADDR) begin
        addr_sh <= pwdata;
      end
      if (wr && paddr == REG_SIZE) begin
        size_sh <= pwdata[`RDM_XFER_W-1:0];
      end
      // One cycle after the final rlast
      done_exp <= rvalid & rready & rlast & (rb_left == 1);
      if (launch) begin
        active      <= 1'b1;
        base        <= addr_sh & ~(`RDM_BURST_BYTES - 1);
        exp_araddr  <= addr_sh & ~(`RDM_BURST_BYTES - 1);
        total_beats <= launch_beats;
        ar_left     <= (launch_beats + `RDM_BURST_BEATS - 1) / `RDM_BURST_BEATS;
        rb_left     <= (launch_beats + `RDM_BURST_BEATS - 1) / `RDM_BURST_BEATS;
        s_idx       <= 0;
      end else begin
        if (done) begin
          active <= 1'b0;
        end
        if (arvalid && arready) begin
          ar_left    <= ar_left - 1;
          exp_araddr <= exp_araddr + `RDM_BURST_BYTES;
        end
        if (rvalid && rready && rlast) begin
          rb_left <= rb_left - 1;
        end
        if (tvalid && tready) begin
          s_idx <= s_idx + 1;
        end
      end
      // In flight from AR handshake to last beat drained
      out_cnt <= out_cnt + ((arvalid && arready) ? 1 : 0) - ((tvalid && tready && tlast) ? 1 : 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB response
  ////////////////////////////////////////////////////////////////////////////
  apb_ready_a: assert property (@(posedge aclk) disable iff (areset)
    psel && penable |-> pready)
    else begin
      fail_cnt++;
      $error("APB access stalled with pready low at %0t", $time);
    end

  // Error only outside the register map
  apb_err_a: assert property (@(posedge aclk) disable iff (areset)
    psel && penable |-> pslverr == !map_hit)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: pslverr got %b expected %b",
             $time, $sampled(pslverr), ~$sampled(map_hit));
    end

  ////////////////////////////////////////////////////////////////////////////
  // AR channel
  ////////////////////////////////////////////////////////////////////////////
  ar_hold_a: assert property (@(posedge aclk) disable iff (areset)
    $past(arvalid && !arready) |-> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      fail_cnt++;
      $error("AR request dropped or changed before arready at %0t", $time);
    end

  ar_count_a: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> ar_left != 0)
    else begin
      fail_cnt++;
      $error("AR issued beyond the bursts of the transfer at %0t", $time);
    end

  ar_addr_a: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> araddr == exp_araddr)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: araddr got %h expected %h",
             $time, $sampled(araddr), $sampled(exp_araddr));
    end

  ar_len_a: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> arlen == exp_arlen)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: arlen got %0d expected %0d",
             $time, $sampled(arlen), $sampled(exp_arlen));
    end

  out_limit_a: assert property (@(posedge aclk) disable iff (areset)
    out_cnt <= `RDM_MAX_OUTSTANDING)
    else begin
      fail_cnt++;
      $error("More than %0d bursts in flight at %0t", `RDM_MAX_OUTSTANDING, $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stream and completion
  ////////////////////////////////////////////////////////////////////////////
  t_hold_a: assert property (@(posedge aclk) disable iff (areset)
    $past(tvalid && !tready) |-> tvalid && $stable(tdata) && $stable(tlast))
    else begin
      fail_cnt++;
      $error("Stream beat dropped or changed under back-pressure at %0t", $time);
    end

  // Also catches lost or duplicated beats
  t_data_a: assert property (@(posedge aclk) disable iff (areset)
    tvalid && tready |-> tdata == exp_tdata)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: tdata got %h expected %h",
             $time, $sampled(tdata), $sampled(exp_tdata));
    end

  t_last_a: assert property (@(posedge aclk) disable iff (areset)
    tvalid && tready |-> tlast == exp_tlast)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: tlast got %b expected %b",
             $time, $sampled(tlast), $sampled(exp_tlast));
    end

  // Previous stream complete when the next transfer starts
  t_count_a: assert property (@(posedge aclk) disable iff (areset)
    launch |-> s_idx == total_beats)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: beats drained got %0d expected %0d",
             $time, $sampled(s_idx), $sampled(total_beats));
    end

  done_a: assert property (@(posedge aclk) disable iff (areset)
    done == done_exp)
    else begin
      fail_cnt++;
      $error("MISMATCH at %0t: done got %b expected %b",
             $time, $sampled(done), $sampled(done_exp));
    end

endmodule : rdm_chk

bind rdm_top rdm_chk chk_i (.*);

// ==== dv/rdm_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Read DMA testbench, AXI slave returns each beat's byte address as data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rdm_defs.svh"

module rdm_tb
  import rdm_pkg::*;
();

  // Beats of tests 2 to 5, and the stall of test 4
  localparam int TOTAL_BEATS  = 25 + 650 + 1024 + 10;
  localparam int STALL_CYCLES = 900;
  localparam int WATCHDOG_NS  = TOTAL_BEATS * 40 + STALL_CYCLES * 20 + 40000;

  logic                       aclk;
  logic                       areset;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`RDM_APB_ADDR_W-1:0] paddr;
  logic [`RDM_DATA_W-1:0]     pwdata;
  logic [`RDM_DATA_W-1:0]     prdata;
  logic                       pready;
  logic                       pslverr;
  logic                       arvalid;
  logic                       arready;
  logic [`RDM_ADDR_W-1:0]     araddr;
  logic [7:0]                 arlen;
  logic                       rvalid;
  logic                       rready;
  logic [`RDM_DATA_W-1:0]     rdata;
  logic                       rlast;
  logic                       tvalid;
  logic                       tready;
  logic [`RDM_DATA_W-1:0]     tdata;
  logic                       tlast;
  logic                       done;

  int          errors    = 0;
  int          tests_run = 0;
  logic        stall     = 1'b0;
  logic [31:0] rng_state = 32'd6379;
  // Accepted AR requests, oldest first
  logic [31:0] ar_addr_q[$];
  logic [7:0]  ar_len_q[$];
  int          beat_idx  = 0;

  rdm_top dut_i (.*);

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int failure_count();
    return errors + dut_i.chk_i.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // AXI slave memory model and stream sink
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (!areset) begin
      if (arvalid && arready) begin
        ar_addr_q.push_back(araddr);
        ar_len_q.push_back(arlen);
      end
      if (rvalid && rready) begin
        if (rlast) begin
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
    #1;
    rng_state = xorshift(rng_state);
    arready = rng_state[0];
    // tready high three times in four unless stalled
    tready = ~stall & (rng_state[2:1] != 2'b00);
    rvalid = 1'b0;
    rlast  = 1'b0;
    if (ar_addr_q.size() != 0 && rng_state[4:3] != 2'b00) begin
      rvalid = 1'b1;
      rdata  = ar_addr_q[0] + (beat_idx << `RDM_BEAT_BYTES_LOG);
      rlast  = (beat_idx == ar_len_q[0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB driver and helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge aclk);
    #1;
    penable = 1'b1;
    @(posedge aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge aclk);
    #1;
    penable = 1'b1;
    // Access phase, read data is combinational
    @(negedge aclk);
    data = prdata;
    err  = pslverr;
    @(posedge aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
    else begin
      $error("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Done pulse, then the FIFO runs empty
  task automatic wait_transfer(input int limit);
    int n;
    n = 0;
    @(negedge aclk);
    while (!done && n < limit) begin
      @(negedge aclk);
      n++;
    end
    while (tvalid && n < limit) begin
      @(negedge aclk);
      n++;
    end
    assert (n < limit)
    else begin
      $error("Transfer did not finish within %0d cycles", limit);
      errors++;
    end
    @(posedge aclk);
    #1;
  endtask

  task automatic start_transfer(input logic [31:0] addr, input logic [31:0] bytes);
    apb_write(REG_ADDR, addr);
    apb_write(REG_SIZE, bytes);
    apb_write(REG_CTRL, 32'h1);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d %s finished, %0d failures so far", tests_run, name, failure_count());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic        err;
    areset  = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rlast   = 1'b0;
    tready  = 1'b0;
    repeat (3) @(posedge aclk);
    #1;
    areset = 1'b0;

    // Readback, unmapped address, start with zero size
    apb_write(REG_ADDR, 32'h0000_1234);
    apb_write(REG_SIZE, 32'd100);
    apb_read(REG_ADDR, rd, err);
    check_value("ADDR readback", rd, 32'h0000_1234);
    apb_read(REG_SIZE, rd, err);
    check_value("SIZE readback", rd, 32'd100);
    apb_read(8'h10, rd, err);
    check_value("pslverr", err, 1);
    apb_write(REG_SIZE, 32'd0);
    apb_write(REG_CTRL, 32'h1);
    repeat (4) @(posedge aclk);
    #1;
    apb_read(REG_CTRL, rd, err);
    check_value("busy", rd[0], 0);
    finish_test("registers");

    // One partial burst from an unaligned address
    start_transfer(32'h0000_1234, 32'd100);
    wait_transfer(1000);
    finish_test("single partial burst");

    // Two full bursts and a remainder of 138 beats
    start_transfer(32'h0000_4000, 32'd2600);
    wait_transfer(4000);
    finish_test("multi-burst");

    // FIFO fills to the outstanding limit while the sink stalls
    @(negedge aclk);
    stall = 1'b1;
    @(posedge aclk);
    #1;
    start_transfer(32'h0000_8000, 32'd4096);
    repeat (STALL_CYCLES) @(posedge aclk);
    @(negedge aclk);
    stall = 1'b0;
    wait_transfer(6000);
    finish_test("back-pressure");

    // Sticky done flag and a start while busy
    apb_write(REG_STATUS, 32'h1);
    apb_read(REG_STATUS, rd, err);
    check_value("STATUS done before start", rd[0], 0);
    start_transfer(32'h0002_0000, 32'd40);
    apb_write(REG_CTRL, 32'h1);
    wait_transfer(1000);
    apb_read(REG_STATUS, rd, err);
    check_value("STATUS done", rd[0], 1);
    apb_write(REG_STATUS, 32'h1);
    apb_read(REG_STATUS, rd, err);
    check_value("STATUS done after clear", rd[0], 0);
    apb_read(REG_CTRL, rd, err);
    check_value("busy after done", rd[0], 0);
    finish_test("completion");

    $display("Tests run %0d, failures %0d", tests_run, failure_count());
    if (failure_count() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule : rdm_tb

// ==== vlog.f ====
+incdir+logic
logic/rdm_pkg.sv
logic/rdm_ctrl_if.sv
logic/rdm_apb_regs.sv
logic/rdm_burst_engine.sv
logic/rdm_read_fifo.sv
logic/rdm_top.sv
dv/rdm_chk.sv
dv/rdm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the read DMA testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rdm_tb \
  -Mdir obj_dir || { echo "run.sh: build failed"; exit 1; }
OUT=$(./obj_dir/Vrdm_tb +verilator+error+limit+1000)
echo "$OUT"
echo "$OUT" | grep -qx "STATUS: PASS" && echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
